// File: list.f
source/spi_config_pkg.sv
source/stream_types_pkg.sv
source/stream_fifo.sv
source/spi_master.sv
source/spi_bridge_top.sv
verification/spi_slave_model.sv
verification/spi_bridge_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 \
  --top-module spi_bridge_tb \
  -o spi_bridge_sim \
  -f list.f

./obj_dir/spi_bridge_sim > sim.log 2>&1
cat sim.log

if grep -qx "test passed" sim.log; then
  echo "run_sim: simulation passed"
  exit 0
fi

echo "run_sim: simulation failed"
exit 1

// File: source/spi_bridge_top.sv
`timescale 1ns/10ps

// Byte stream to SPI bridge with transmit and receive queues
module spi_bridge_top #(
  parameter int                        tx_depth = 8,
  parameter int                        rx_depth = 8,
  parameter spi_config_pkg::spi_mode_t spi_mode = spi_config_pkg::spi_mode_0
) (
  input  logic                       clock,
  input  logic                       reset,

  input  logic                       tx_valid,
  output logic                       tx_ready,
  input  stream_types_pkg::tx_beat_t tx_beat,

  output logic                       rx_valid,
  input  logic                       rx_ready,
  output stream_types_pkg::rx_beat_t rx_beat,

  output logic                       sck,
  output logic                       sck_en,
  output logic                       ssel_n,
  output logic                       mosi,
  input  logic                       miso,

  output logic                       overrun
);

  import stream_types_pkg::*;

  logic     master_in_valid;
  logic     master_in_ready;
  tx_beat_t master_in_beat;

  logic     master_rx_valid;
  rx_beat_t master_rx_beat;
  logic     rx_in_ready;

  stream_fifo #(
    .depth     (tx_depth),
    .payload_t (tx_beat_t)
  ) tx_queue (
    .clock     (clock),
    .reset     (reset),
    .in_valid  (tx_valid),
    .in_ready  (tx_ready),
    .in_data   (tx_beat),
    .out_valid (master_in_valid),
    .out_ready (master_in_ready),
    .out_data  (master_in_beat)
  );

  spi_master #(
    .spi_mode (spi_mode)
  ) master (
    .clock    (clock),
    .reset    (reset),
    .in_valid (master_in_valid),
    .in_ready (master_in_ready),
    .in_beat  (master_in_beat),
    .sck      (sck),
    .sck_en   (sck_en),
    .ssel_n   (ssel_n),
    .mosi     (mosi),
    .miso     (miso),
    .rx_valid (master_rx_valid),
    .rx_beat  (master_rx_beat)
  );

  // The queue drops a pulse that arrives while it cannot take it
  stream_fifo #(
    .depth     (rx_depth),
    .payload_t (rx_beat_t)
  ) rx_queue (
    .clock     (clock),
    .reset     (reset),
    .in_valid  (master_rx_valid),
    .in_ready  (rx_in_ready),
    .in_data   (master_rx_beat),
    .out_valid (rx_valid),
    .out_ready (rx_ready),
    .out_data  (rx_beat)
  );

  // Sticky until reset
  always_ff @(posedge clock) begin
    if (reset) begin
      overrun <= 1'b0;
    end else if (master_rx_valid && !rx_in_ready) begin
      overrun <= 1'b1;
    end
  end

endmodule

// File: source/spi_config_pkg.sv
// SPI mode and geometry shared by the master and the bridge top level
package spi_config_pkg;

  // Bits shifted per SPI transfer
  localparam int spi_byte_bits = 8;

  // Clock polarity only
  // Both modes sample on the leading SCK edge (CPHA = 0)
  typedef enum logic {
    spi_mode_0 = 1'b0,
    spi_mode_2 = 1'b1
  } spi_mode_t;

  // Clocks that chip-select leads the first SCK edge of a frame
  localparam int select_lead_cycles = 8;

endpackage

// File: source/spi_master.sv
`timescale 1ns/10ps

// Synchronous SPI master, CPHA = 0 with either clock polarity
// SCK is the system clock itself and sck_en marks the cycles that carry bits
module spi_master #(
  parameter spi_config_pkg::spi_mode_t spi_mode = spi_config_pkg::spi_mode_0
) (
  input  logic                       clock,
  input  logic                       reset,

  input  logic                       in_valid,
  output logic                       in_ready,
  input  stream_types_pkg::tx_beat_t in_beat,

  output logic                       sck,
  output logic                       sck_en,
  output logic                       ssel_n,
  output logic                       mosi,
  input  logic                       miso,

  output logic                       rx_valid,
  output stream_types_pkg::rx_beat_t rx_beat
);

  import spi_config_pkg::*;
  import stream_types_pkg::*;

  typedef enum logic [4:0] {
    st_idle   = 5'b00001,
    st_select = 5'b00010,
    st_busy   = 5'b00100,
    st_last   = 5'b01000,
    st_done   = 5'b10000
  } state_t;

  localparam int count_bits = $clog2(spi_byte_bits);

  // Terminal counts of the shared bit counter
  localparam logic [count_bits-1:0] byte_end_count = count_bits'(spi_byte_bits - 1);
  localparam logic [count_bits-1:0] lead_end_count = count_bits'(select_lead_cycles - 1);
  localparam logic [count_bits-1:0] done_end_count = count_bits'(1);

  state_t state;
  state_t state_next;

  logic [count_bits-1:0]    bit_count;
  logic [spi_byte_bits-1:0] tx_shift;
  logic [spi_byte_bits-1:0] rx_shift;

  logic frame_last;
  logic first_pending;
  logic byte_end;
  logic take;

  // Mode 2 idles high, so the bit edges land on the falling clock
  assign sck    = (spi_mode == spi_mode_2) ? ~clock : clock;
  assign ssel_n = (state == st_idle);
  assign mosi   = tx_shift[spi_byte_bits-1];

  assign byte_end = sck_en && (bit_count == byte_end_count);

  // New beats enter only from idle or on a byte boundary of a running frame
  assign in_ready = (state == st_idle) || ((state == st_busy) && byte_end);
  assign take     = in_valid && in_ready;

  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        if (in_valid) begin
          state_next = st_select;
        end
      end
      st_select: begin
        if (bit_count == lead_end_count) begin
          state_next = frame_last ? st_last : st_busy;
        end
      end
      st_busy: begin
        // An empty input at the boundary closes the frame early
        if (byte_end) begin
          if (!in_valid) begin
            state_next = st_done;
          end else if (in_beat.last) begin
            state_next = st_last;
          end else begin
            state_next = st_busy;
          end
        end
      end
      st_last: begin
        if (byte_end) begin
          state_next = st_done;
        end
      end
      st_done: begin
        // Holds chip-select for two clocks after SCK stops
        if (bit_count == done_end_count) begin
          state_next = st_idle;
        end
      end
      default: begin
        state_next = st_idle;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state         <= st_idle;
      bit_count     <= '0;
      sck_en        <= 1'b0;
      rx_valid      <= 1'b0;
      frame_last    <= 1'b0;
      first_pending <= 1'b0;
    end else begin
      state <= state_next;

      // Counter wraps across select, every byte and into done
      if (state == st_idle || state_next == st_idle) begin
        bit_count <= '0;
      end else begin
        bit_count <= bit_count + 1'b1;
      end

      sck_en   <= (state_next == st_busy) || (state_next == st_last);
      rx_valid <= byte_end;

      if (take) begin
        frame_last <= in_beat.last;
      end

      if (take && state == st_idle) begin
        first_pending <= 1'b1;
      end else if (byte_end) begin
        first_pending <= 1'b0;
      end
    end
  end

  // Transmit shifter, MSB first, loaded on every accepted beat
  always_ff @(posedge clock) begin
    if (take) begin
      tx_shift <= in_beat.data;
    end else if (state == st_busy || state == st_last) begin
      tx_shift <= {tx_shift[spi_byte_bits-2:0], 1'b0};
    end
  end

  // Receive shifter samples miso on every bit clock
  always_ff @(posedge clock) begin
    if (sck_en) begin
      rx_shift <= {rx_shift[spi_byte_bits-2:0], miso};
    end
  end

  always_ff @(posedge clock) begin
    if (byte_end) begin
      rx_beat.data  <= {rx_shift[spi_byte_bits-2:0], miso};
      rx_beat.first <= first_pending;
      rx_beat.last  <= (state_next == st_done);
    end
  end

endmodule

// File: source/stream_fifo.sv
`timescale 1ns/10ps

// Synchronous FIFO with valid/ready on both sides
// depth must be a power of two, at least 2
module stream_fifo #(
  parameter int  depth     = 8,
  parameter type payload_t = logic [7:0]
) (
  input  logic     clock,
  input  logic     reset,

  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,

  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  localparam int addr_bits = $clog2(depth);

  payload_t storage [depth];

  // Pointers carry one wrap bit above the address
  logic [addr_bits:0] wr_ptr;
  logic [addr_bits:0] rd_ptr;

  logic live;
  logic full;
  logic empty;
  logic write;
  logic read;

  // Same slot on different laps means every slot is occupied
  assign full = (wr_ptr[addr_bits] != rd_ptr[addr_bits]) &&
                (wr_ptr[addr_bits-1:0] == rd_ptr[addr_bits-1:0]);
  assign empty = (wr_ptr == rd_ptr);

  assign out_valid = !empty;
  assign out_data  = storage[rd_ptr[addr_bits-1:0]];

  // A read in the same cycle frees the slot that a full FIFO needs
  assign in_ready = live && (!full || out_ready);

  assign write = in_valid && in_ready;
  assign read  = out_valid && out_ready;

  // Input side stays closed until the first clock out of reset
  always_ff @(posedge clock) begin
    if (reset) begin
      live <= 1'b0;
    end else begin
      live <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (write) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (read) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (write) begin
      storage[wr_ptr[addr_bits-1:0]] <= in_data;
    end
  end

endmodule

// File: source/stream_types_pkg.sv
// Beat formats of the transmit and receive byte streams
package stream_types_pkg;

  typedef logic [7:0] beat_data_t;

  // Host to SPI direction
  // last marks the final byte of a chip-select frame
  typedef struct packed {
    beat_data_t data;
    logic       last;
  } tx_beat_t;

  // SPI to host direction
  // first and last bracket the bytes received in one frame
  typedef struct packed {
    beat_data_t data;
    logic       first;
    logic       last;
  } rx_beat_t;

endpackage

// File: verification/spi_bridge_tb.sv
`timescale 1ns/10ps

module spi_bridge_tb;

  import spi_config_pkg::*;
  import stream_types_pkg::*;

  localparam int          clock_period  = 100;
  localparam int          tx_depth      = 8;
  localparam int          rx_depth      = 8;
  localparam int          max_len       = 16;
  localparam logic [31:0] lcg_base_seed = 32'd30534;

  // One frame per row
  // rx_pattern replays every 8 clocks while the frame runs
  typedef struct packed {
    logic [7:0]  length;
    logic [15:0] seed;
    logic [7:0]  rx_pattern;
  } row_t;

  localparam int   row_count = 6;
  localparam row_t rows [row_count] = '{
    '{8'd1,  16'h0101, 8'hFF},
    '{8'd5,  16'h2A3C, 8'hFF},
    '{8'd3,  16'h7711, 8'hA5},
    '{8'd6,  16'h0C40, 8'h00},
    '{8'd8,  16'h5E21, 8'hFF},
    '{8'd12, 16'h1B96, 8'h00}
  };

  logic     clock = 1'b0;
  logic     reset;
  logic     tx_valid;
  logic     tx_ready;
  tx_beat_t tx_beat;
  logic     rx_valid;
  logic     rx_ready;
  rx_beat_t rx_beat;
  logic     sck;
  logic     sck_en;
  logic     ssel_n;
  logic     mosi;
  logic     miso;
  logic     overrun;

  logic [7:0] frame_bytes [max_len];
  rx_beat_t   rx_log [$];
  logic       ssel_prev = 1'b1;
  logic       expect_overrun = 1'b0;

  int tx_accepted = 0;
  int tx_stalls   = 0;
  int sck_edges   = 0;
  int stray_edges = 0;
  int selects     = 0;
  int edges_start = 0;
  int sent_total  = 0;
  int check_count = 0;
  int error_count = 0;

  spi_bridge_top #(
    .tx_depth (tx_depth),
    .rx_depth (rx_depth),
    .spi_mode (spi_mode_0)
  ) UUT (
    .clock    (clock),
    .reset    (reset),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready),
    .tx_beat  (tx_beat),
    .rx_valid (rx_valid),
    .rx_ready (rx_ready),
    .rx_beat  (rx_beat),
    .sck      (sck),
    .sck_en   (sck_en),
    .ssel_n   (ssel_n),
    .mosi     (mosi),
    .miso     (miso),
    .overrun  (overrun)
  );

  spi_slave_model slave (
    .sck    (sck),
    .sck_en (sck_en),
    .ssel_n (ssel_n),
    .mosi   (mosi),
    .miso   (miso)
  );

  always #(clock_period / 2) clock = ~clock;

  // Monitors on the rising edge
  always @(posedge clock) begin
    if (!reset) begin
      if (tx_valid && tx_ready) begin
        tx_accepted = tx_accepted + 1;
      end
      if (tx_valid && !tx_ready) begin
        tx_stalls = tx_stalls + 1;
      end
      if (rx_valid && rx_ready) begin
        rx_log.push_back(rx_beat);
      end
      if (ssel_prev && !ssel_n) begin
        selects = selects + 1;
      end
      ssel_prev = ssel_n;
    end
  end

  // Qualified SCK edges, and any that fall outside chip-select
  always @(posedge sck) begin
    if (!reset && sck_en) begin
      sck_edges = sck_edges + 1;
      if (ssel_n) begin
        stray_edges = stray_edges + 1;
      end
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic int watchdog_clocks();
    int total;
    int r;
    total = 0;
    for (r = 0; r < row_count; r++) begin
      total += 20 + 10 * int'(rows[r].length);
    end
    return 2 * total;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
    end
  endtask

  task automatic send_frame(input int len);
    int idx;
    idx = 0;
    while (idx < len) begin
      @(negedge clock);
      tx_valid     = 1'b1;
      tx_beat.data = frame_bytes[idx];
      tx_beat.last = (idx == len - 1);
      // tx_ready holds until the next rising edge
      if (tx_ready) begin
        idx++;
      end
    end
    @(negedge clock);
    tx_valid = 1'b0;
  endtask

  task automatic pace_rx_ready(input logic [7:0] pattern, input int edge_target);
    logic [2:0] phase;
    phase = 3'd0;
    while ((sck_edges - edges_start) < edge_target || !ssel_n) begin
      @(negedge clock);
      rx_ready = pattern[phase];
      phase    = phase + 3'd1;
    end
    rx_ready = 1'b1;
  endtask

  task automatic run_row(input int r);
    row_t        row;
    int          len;
    int          expected_beats;
    int          errors_before;
    int          selects_start;
    int          stray_start;
    int          stalls_start;
    int          k;
    logic [31:0] lcg_state;
    logic [7:0]  expected_data;
    rx_beat_t    beat;

    row       = rows[r];
    len       = int'(row.length);
    lcg_state = lcg_base_seed + {16'h0000, row.seed};
    for (k = 0; k < len; k++) begin
      lcg_state      = lcg_next(lcg_state);
      frame_bytes[k] = lcg_state[23:16];
    end
    sent_total += len;

    // With nothing draining, only a full receive queue survives the frame
    expected_beats = len;
    if (row.rx_pattern == 8'h00 && len > rx_depth) begin
      expected_beats = rx_depth;
      expect_overrun = 1'b1;
    end

    errors_before = error_count;
    edges_start   = sck_edges;
    selects_start = selects;
    stray_start   = stray_edges;
    stalls_start  = tx_stalls;

    fork
      send_frame(len);
      pace_rx_ready(row.rx_pattern, spi_byte_bits * len);
    join

    while (rx_log.size() < expected_beats) begin
      @(negedge clock);
    end
    @(negedge clock);

    check_value("rx_valid", 32'(rx_valid), 32'd0);
    check_value("received beats", rx_log.size(), expected_beats);
    for (k = 0; k < expected_beats; k++) begin
      beat          = rx_log.pop_front();
      expected_data = (k == 0) ? 8'h00 : ~frame_bytes[k-1];
      check_value("rx_beat.data", 32'(beat.data), 32'(expected_data));
      check_value("rx_beat.first", 32'(beat.first), 32'(k == 0));
      check_value("rx_beat.last", 32'(beat.last), 32'(k == len - 1));
    end

    check_value("ssel_n", 32'(ssel_n), 32'd1);
    check_value("sck edges", sck_edges - edges_start, spi_byte_bits * len);
    check_value("sck edges outside select", stray_edges - stray_start, 32'd0);
    check_value("select periods", selects - selects_start, 32'd1);
    check_value("overrun", 32'(overrun), 32'(expect_overrun));

    // Beat 0 leaves the queue at once and the next one waits out the lead and a byte
    check_value("tx_ready stalls seen", 32'(tx_stalls > stalls_start),
                32'(len > tx_depth + 1));

    $display("row %0d: %0d bytes, %0d beats, %0d errors", r, len, expected_beats,
             error_count - errors_before);
  endtask

  initial begin
    #(watchdog_clocks() * clock_period);
    $display("timeout: run did not finish within %0d clocks", watchdog_clocks());
    $display("test failed");
    $finish;
  end

  initial begin
    int r;
    reset    = 1'b1;
    tx_valid = 1'b0;
    tx_beat  = '0;
    rx_ready = 1'b1;
    repeat (5) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    for (r = 0; r < row_count; r++) begin
      run_row(r);
    end
    check_value("accepted transmit beats", tx_accepted, sent_total);

    $display("rows %0d, checks %0d, errors %0d", row_count, check_count, error_count);
    if (error_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: verification/spi_slave_model.sv
`timescale 1ns/10ps

// Behavioral SPI slave for CPHA = 0 with SCK idling low
// Each byte is answered with the inverse of the byte received before it in the frame
module spi_slave_model (
  input  logic sck,
  input  logic sck_en,
  input  logic ssel_n,
  input  logic mosi,
  output logic miso
);

  logic [7:0] in_shift;
  logic [2:0] in_count;
  logic [7:0] reply;
  logic [2:0] out_count;
  logic       miso_bit = 1'b0;

  assign miso = miso_bit;

  // Sample mosi on the rising edge
  // A finished byte sets the reply for the next one
  always @(posedge sck) begin
    if (ssel_n) begin
      in_count <= 3'd0;
      reply    <= 8'h00;
    end else if (sck_en) begin
      in_shift <= {in_shift[6:0], mosi};
      in_count <= in_count + 3'd1;
      if (in_count == 3'd7) begin
        reply <= ~{in_shift[6:0], mosi};
      end
    end
  end

  // Present the reply MSB first on the falling edge
  always @(negedge sck) begin
    if (ssel_n) begin
      out_count <= 3'd0;
      miso_bit  <= 1'b0;
    end else if (sck_en) begin
      miso_bit  <= reply[3'd7 - out_count];
      out_count <= out_count + 3'd1;
    end
  end

endmodule
